//--- Bender.yml
package:
  name: mem_2r2w

sources:
  - files:
      - source/mem_2r2w_pkg.sv
      - source/bank_array.sv
      - source/row_cache.sv
      - source/location_map.sv
      - source/read_select.sv
      - source/write_steer.sv
      - source/mem_2r2w_top.sv
  - target: test
    files:
      - test/tb_mem_2r2w.sv

//--- mem_2r2w_top.f
source/mem_2r2w_pkg.sv
source/bank_array.sv
source/row_cache.sv
source/location_map.sv
source/read_select.sv
source/write_steer.sv
source/mem_2r2w_top.sv
test/tb_mem_2r2w.sv

//--- source/bank_array.sv
`default_nettype none

module bank_array
  import mem_2r2w_pkg::*;
#(
  parameter int WIDTH    = DEFAULT_WIDTH,
  parameter int NUM_VBNK = DEFAULT_NUM_VBNK,
  parameter int NUM_VROW = DEFAULT_NUM_VROW,
  localparam int BNK_W = $clog2(NUM_VBNK),
  localparam int ROW_W = $clog2(NUM_VROW)
) (
  input  logic                               clk,
  input  logic                               a_en,
  input  logic [BNK_W-1:0]                   a_bank,
  input  logic [ROW_W-1:0]                   a_row,
  input  logic [WIDTH-1:0]                   a_data,
  input  logic                               b_en,
  input  logic [BNK_W-1:0]                   b_bank,
  input  logic [ROW_W-1:0]                   b_row,
  input  logic [WIDTH-1:0]                   b_data,
  input  logic [NUM_RD_PORTS-1:0]            rd_en,
  input  logic [NUM_RD_PORTS-1:0][BNK_W-1:0] rd_bank,
  input  logic [NUM_RD_PORTS-1:0][ROW_W-1:0] rd_row,
  output logic [NUM_RD_PORTS-1:0][WIDTH-1:0] rd_data
);

  wire [WIDTH-1:0] bank_dout [NUM_RD_PORTS][NUM_VBNK];
  logic [NUM_RD_PORTS-1:0][BNK_W-1:0] rd_bank_q;

  for (genvar b = 0; b < NUM_VBNK; b++) begin : g_bank
    logic             a_hit, b_hit, we;
    logic [ROW_W-1:0] wr_row;
    logic [WIDTH-1:0] wr_data;

    // a and b never meet in one bank, so each bank has one write port.
    assign a_hit   = a_en & (a_bank == BNK_W'(b));
    assign b_hit   = b_en & (b_bank == BNK_W'(b));
    assign we      = a_hit | b_hit;
    assign wr_row  = a_hit ? a_row : b_row;
    assign wr_data = a_hit ? a_data : b_data;

    for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_copy
      logic [WIDTH-1:0] ram [NUM_VROW];
      logic [WIDTH-1:0] dout_q;

      always_ff @(posedge clk) begin
        if (we) begin
          ram[wr_row] <= wr_data;
        end
        if (rd_en[p] && (rd_bank[p] == BNK_W'(b))) begin
          dout_q <= ram[rd_row[p]];
        end
      end

      assign bank_dout[p][b] = dout_q;
    end
  end

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_port
    always_ff @(posedge clk) begin
      if (rd_en[p]) begin
        rd_bank_q[p] <= rd_bank[p];
      end
    end

    assign rd_data[p] = bank_dout[p][rd_bank_q[p]];

    // an undefined bank or row selects no real bank word.
    a_rd_bank_range: assert property (@(posedge clk)
      rd_en[p] |-> !$isunknown({rd_bank[p], rd_row[p]}))
      else $error("read of an undefined bank or row");
  end

endmodule

`default_nettype wire

//--- source/location_map.sv
`default_nettype none

module location_map
  import mem_2r2w_pkg::*;
#(
  parameter int NUM_VBNK = DEFAULT_NUM_VBNK,
  parameter int NUM_VROW = DEFAULT_NUM_VROW,
  localparam int BNK_W = $clog2(NUM_VBNK),
  localparam int ROW_W = $clog2(NUM_VROW)
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [NUM_WR_PORTS-1:0][ROW_W-1:0] wr_look_row,
  output logic [NUM_WR_PORTS-1:0]            wr_look_vld,
  output logic [NUM_WR_PORTS-1:0][BNK_W-1:0] wr_look_bank,
  input  logic [NUM_RD_PORTS-1:0][ROW_W-1:0] rd_look_row,
  output logic [NUM_RD_PORTS-1:0]            rd_look_vld,
  output logic [NUM_RD_PORTS-1:0][BNK_W-1:0] rd_look_bank,
  input  logic [NUM_WR_PORTS-1:0]            upd_en,
  input  logic [NUM_WR_PORTS-1:0][ROW_W-1:0] upd_row,
  input  logic [NUM_WR_PORTS-1:0]            upd_vld,
  input  logic [NUM_WR_PORTS-1:0][BNK_W-1:0] upd_bank,
  output logic                               ready
);

  logic             vld   [NUM_VROW];
  logic [BNK_W-1:0] owner [NUM_VROW];
  logic [ROW_W-1:0] clr_row;

  // sweep one row per cycle after reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      clr_row <= '0;
      ready   <= 1'b0;
    end else if (!ready) begin
      clr_row <= clr_row + 1'b1;
      if (&clr_row) begin
        ready <= 1'b1;
      end
    end
  end

  // updates always target different rows.
  always_ff @(posedge clk) begin
    if (!ready) begin
      vld[clr_row] <= 1'b0;
    end else begin
      for (int i = 0; i < NUM_WR_PORTS; i++) begin
        if (upd_en[i]) begin
          vld[upd_row[i]]   <= upd_vld[i];
          owner[upd_row[i]] <= upd_bank[i];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_WR_PORTS; i++) begin
      wr_look_vld[i]  = vld[wr_look_row[i]];
      wr_look_bank[i] = owner[wr_look_row[i]];
    end
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_look_vld[p]  = vld[rd_look_row[p]];
      rd_look_bank[p] = owner[rd_look_row[p]];
    end
  end

  a_no_upd_during_clear: assert property (@(posedge clk) disable iff (rst)
    !ready |-> (upd_en == '0))
    else $error("map update while the clearing sweep runs");

endmodule

`default_nettype wire

//--- source/mem_2r2w_pkg.sv
`default_nettype none

package mem_2r2w_pkg;

  // port counts are fixed by the banking scheme.
  localparam int NUM_RD_PORTS = 2;
  localparam int NUM_WR_PORTS = 2;

  // default geometry; the top level passes these down.
  localparam int DEFAULT_WIDTH    = 32;
  localparam int DEFAULT_NUM_VBNK = 8;
  localparam int DEFAULT_NUM_VROW = 64;

  // address layout: bank index in the low bits, row index above it.

endpackage

`default_nettype wire

//--- source/mem_2r2w_top.sv
`default_nettype none

module mem_2r2w_top
  import mem_2r2w_pkg::*;
#(
  parameter int WIDTH    = DEFAULT_WIDTH,
  parameter int NUM_VBNK = DEFAULT_NUM_VBNK,
  parameter int NUM_VROW = DEFAULT_NUM_VROW,
  localparam int BNK_W = $clog2(NUM_VBNK),
  localparam int ROW_W = $clog2(NUM_VROW),
  localparam int ADR_W = BNK_W + ROW_W
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [NUM_WR_PORTS-1:0]                write,
  input  logic [NUM_WR_PORTS-1:0][ADR_W-1:0]     wr_adr,
  input  logic [NUM_WR_PORTS-1:0][WIDTH-1:0]     din,
  input  logic [NUM_RD_PORTS-1:0]                read,
  input  logic [NUM_RD_PORTS-1:0][ADR_W-1:0]     rd_adr,
  output logic [NUM_RD_PORTS-1:0]                rd_vld,
  output logic [NUM_RD_PORTS-1:0][WIDTH-1:0]     rd_dout,
  output logic                                   ready
);

  // write side.
  logic [NUM_WR_PORTS-1:0][ROW_W-1:0] map_wr_row;
  logic [NUM_WR_PORTS-1:0]            map_wr_vld;
  logic [NUM_WR_PORTS-1:0][BNK_W-1:0] map_wr_bank;
  logic [ROW_W-1:0]                   evict_row;
  logic [WIDTH-1:0]                   evict_data;
  logic                               bank_a_en, bank_b_en;
  logic [BNK_W-1:0]                   bank_a_bank, bank_b_bank;
  logic [ROW_W-1:0]                   bank_a_row, bank_b_row;
  logic [WIDTH-1:0]                   bank_a_data, bank_b_data;
  logic                               cache_en;
  logic [ROW_W-1:0]                   cache_row;
  logic [WIDTH-1:0]                   cache_data;
  logic [NUM_WR_PORTS-1:0]            upd_en, upd_vld;
  logic [NUM_WR_PORTS-1:0][ROW_W-1:0] upd_row;
  logic [NUM_WR_PORTS-1:0][BNK_W-1:0] upd_bank;

  // read side.
  logic [NUM_RD_PORTS-1:0][ROW_W-1:0] look_row;
  logic [NUM_RD_PORTS-1:0]            look_vld;
  logic [NUM_RD_PORTS-1:0][BNK_W-1:0] look_bank;
  logic [NUM_RD_PORTS-1:0]            bank_rd_en;
  logic [NUM_RD_PORTS-1:0][BNK_W-1:0] bank_rd_bank;
  logic [NUM_RD_PORTS-1:0][ROW_W-1:0] bank_rd_row, cache_rd_row;
  logic [NUM_RD_PORTS-1:0][WIDTH-1:0] bank_rd_data, cache_rd_data;

  write_steer #(.WIDTH(WIDTH), .NUM_VBNK(NUM_VBNK), .NUM_VROW(NUM_VROW)) write_steer_i (
    .clk, .rst, .ready, .write, .wr_adr, .din,
    .map_wr_row, .map_wr_vld, .map_wr_bank, .evict_row, .evict_data,
    .bank_a_en, .bank_a_bank, .bank_a_row, .bank_a_data,
    .bank_b_en, .bank_b_bank, .bank_b_row, .bank_b_data,
    .cache_en, .cache_row, .cache_data,
    .upd_en, .upd_row, .upd_vld, .upd_bank
  );

  read_select #(.WIDTH(WIDTH), .NUM_VBNK(NUM_VBNK), .NUM_VROW(NUM_VROW)) read_select_i (
    .clk, .rst, .ready, .read, .rd_adr,
    .look_row, .look_vld, .look_bank,
    .bank_rd_en, .bank_rd_bank, .bank_rd_row, .cache_rd_row,
    .bank_rd_data, .cache_rd_data, .rd_vld, .rd_dout
  );

  location_map #(.NUM_VBNK(NUM_VBNK), .NUM_VROW(NUM_VROW)) location_map_i (
    .clk, .rst,
    .wr_look_row(map_wr_row), .wr_look_vld(map_wr_vld), .wr_look_bank(map_wr_bank),
    .rd_look_row(look_row), .rd_look_vld(look_vld), .rd_look_bank(look_bank),
    .upd_en, .upd_row, .upd_vld, .upd_bank, .ready
  );

  row_cache #(.WIDTH(WIDTH), .NUM_VROW(NUM_VROW)) row_cache_i (
    .clk, .wr_en(cache_en), .wr_row(cache_row), .wr_data(cache_data),
    .evict_row, .evict_data, .rd_row(cache_rd_row), .rd_data(cache_rd_data)
  );

  bank_array #(.WIDTH(WIDTH), .NUM_VBNK(NUM_VBNK), .NUM_VROW(NUM_VROW)) bank_array_i (
    .clk,
    .a_en(bank_a_en), .a_bank(bank_a_bank), .a_row(bank_a_row), .a_data(bank_a_data),
    .b_en(bank_b_en), .b_bank(bank_b_bank), .b_row(bank_b_row), .b_data(bank_b_data),
    .rd_en(bank_rd_en), .rd_bank(bank_rd_bank), .rd_row(bank_rd_row), .rd_data(bank_rd_data)
  );

endmodule

`default_nettype wire

//--- source/read_select.sv
`default_nettype none

module read_select
  import mem_2r2w_pkg::*;
#(
  parameter int WIDTH    = DEFAULT_WIDTH,
  parameter int NUM_VBNK = DEFAULT_NUM_VBNK,
  parameter int NUM_VROW = DEFAULT_NUM_VROW,
  localparam int BNK_W = $clog2(NUM_VBNK),
  localparam int ROW_W = $clog2(NUM_VROW),
  localparam int ADR_W = BNK_W + ROW_W
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               ready,
  input  logic [NUM_RD_PORTS-1:0]            read,
  input  logic [NUM_RD_PORTS-1:0][ADR_W-1:0] rd_adr,
  output logic [NUM_RD_PORTS-1:0][ROW_W-1:0] look_row,
  input  logic [NUM_RD_PORTS-1:0]            look_vld,
  input  logic [NUM_RD_PORTS-1:0][BNK_W-1:0] look_bank,
  output logic [NUM_RD_PORTS-1:0]            bank_rd_en,
  output logic [NUM_RD_PORTS-1:0][BNK_W-1:0] bank_rd_bank,
  output logic [NUM_RD_PORTS-1:0][ROW_W-1:0] bank_rd_row,
  output logic [NUM_RD_PORTS-1:0][ROW_W-1:0] cache_rd_row,
  input  logic [NUM_RD_PORTS-1:0][WIDTH-1:0] bank_rd_data,
  input  logic [NUM_RD_PORTS-1:0][WIDTH-1:0] cache_rd_data,
  output logic [NUM_RD_PORTS-1:0]            rd_vld,
  output logic [NUM_RD_PORTS-1:0][WIDTH-1:0] rd_dout
);

  logic [NUM_RD_PORTS-1:0] rd_en;
  logic [NUM_RD_PORTS-1:0] cache_hit;
  logic [NUM_RD_PORTS-1:0] sel_cache_q;

  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_en[p]        = read[p] & ready;
      look_row[p]     = rd_adr[p][ADR_W-1:BNK_W];
      // the cache slot holds this address only if it names the read bank.
      cache_hit[p]    = look_vld[p] & (look_bank[p] == rd_adr[p][BNK_W-1:0]);
      bank_rd_en[p]   = rd_en[p] & ~cache_hit[p];
      bank_rd_bank[p] = rd_adr[p][BNK_W-1:0];
      bank_rd_row[p]  = rd_adr[p][ADR_W-1:BNK_W];
      cache_rd_row[p] = rd_adr[p][ADR_W-1:BNK_W];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld      <= '0;
      sel_cache_q <= '0;
    end else begin
      rd_vld      <= rd_en;
      sel_cache_q <= cache_hit;
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_dout[p] = sel_cache_q[p] ? cache_rd_data[p] : bank_rd_data[p];
    end
  end

endmodule

`default_nettype wire

//--- source/row_cache.sv
`default_nettype none

module row_cache
  import mem_2r2w_pkg::*;
#(
  parameter int WIDTH    = DEFAULT_WIDTH,
  parameter int NUM_VROW = DEFAULT_NUM_VROW,
  localparam int ROW_W = $clog2(NUM_VROW)
) (
  input  logic                               clk,
  input  logic                               wr_en,
  input  logic [ROW_W-1:0]                   wr_row,
  input  logic [WIDTH-1:0]                   wr_data,
  input  logic [ROW_W-1:0]                   evict_row,
  output logic [WIDTH-1:0]                   evict_data,
  input  logic [NUM_RD_PORTS-1:0][ROW_W-1:0] rd_row,
  output logic [NUM_RD_PORTS-1:0][WIDTH-1:0] rd_data
);

  logic [WIDTH-1:0] mem [NUM_VROW];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  // old word of the slot, read before the same-edge overwrite.
  assign evict_data = mem[evict_row];

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_data[p] <= mem[rd_row[p]];
    end
  end

endmodule

`default_nettype wire

//--- source/write_steer.sv
`default_nettype none

module write_steer
  import mem_2r2w_pkg::*;
#(
  parameter int WIDTH    = DEFAULT_WIDTH,
  parameter int NUM_VBNK = DEFAULT_NUM_VBNK,
  parameter int NUM_VROW = DEFAULT_NUM_VROW,
  localparam int BNK_W = $clog2(NUM_VBNK),
  localparam int ROW_W = $clog2(NUM_VROW),
  localparam int ADR_W = BNK_W + ROW_W
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               ready,
  input  logic [NUM_WR_PORTS-1:0]            write,
  input  logic [NUM_WR_PORTS-1:0][ADR_W-1:0] wr_adr,
  input  logic [NUM_WR_PORTS-1:0][WIDTH-1:0] din,
  output logic [NUM_WR_PORTS-1:0][ROW_W-1:0] map_wr_row,
  input  logic [NUM_WR_PORTS-1:0]            map_wr_vld,
  input  logic [NUM_WR_PORTS-1:0][BNK_W-1:0] map_wr_bank,
  output logic [ROW_W-1:0]                   evict_row,
  input  logic [WIDTH-1:0]                   evict_data,
  output logic                               bank_a_en,
  output logic [BNK_W-1:0]                   bank_a_bank,
  output logic [ROW_W-1:0]                   bank_a_row,
  output logic [WIDTH-1:0]                   bank_a_data,
  output logic                               bank_b_en,
  output logic [BNK_W-1:0]                   bank_b_bank,
  output logic [ROW_W-1:0]                   bank_b_row,
  output logic [WIDTH-1:0]                   bank_b_data,
  output logic                               cache_en,
  output logic [ROW_W-1:0]                   cache_row,
  output logic [WIDTH-1:0]                   cache_data,
  output logic [NUM_WR_PORTS-1:0]            upd_en,
  output logic [NUM_WR_PORTS-1:0][ROW_W-1:0] upd_row,
  output logic [NUM_WR_PORTS-1:0]            upd_vld,
  output logic [NUM_WR_PORTS-1:0][BNK_W-1:0] upd_bank
);

  logic [NUM_WR_PORTS-1:0][BNK_W-1:0] wr_bank;
  logic [NUM_WR_PORTS-1:0][ROW_W-1:0] wr_row;
  logic [NUM_WR_PORTS-1:0]            wr_en;
  logic                               same_adr;
  logic                               w0, w1;
  logic                               conflict;
  logic                               evicting;

  always_comb begin
    for (int i = 0; i < NUM_WR_PORTS; i++) begin
      wr_bank[i] = wr_adr[i][BNK_W-1:0];
      wr_row[i]  = wr_adr[i][ADR_W-1:BNK_W];
      wr_en[i]   = write[i] & ready;
    end
  end

  // port 1 wins when both ports hit one address.
  assign same_adr = wr_en[0] & wr_en[1] & (wr_adr[0] == wr_adr[1]);
  assign w0       = wr_en[0] & ~same_adr;
  assign w1       = wr_en[1];
  assign conflict = w0 & w1 & (wr_bank[0] == wr_bank[1]);

  // slot of row r1 holds another bank's word.
  assign evicting = conflict & map_wr_vld[1] & (map_wr_bank[1] != wr_bank[1]);

  assign map_wr_row = wr_row;
  assign evict_row  = wr_row[1];

  assign bank_a_en   = w0;
  assign bank_a_bank = wr_bank[0];
  assign bank_a_row  = wr_row[0];
  assign bank_a_data = din[0];

  // port b carries write 1, or the write-back of an evicted word.
  assign bank_b_en   = conflict ? evicting : w1;
  assign bank_b_bank = conflict ? map_wr_bank[1] : wr_bank[1];
  assign bank_b_row  = wr_row[1];
  assign bank_b_data = conflict ? evict_data : din[1];

  assign cache_en   = conflict;
  assign cache_row  = wr_row[1];
  assign cache_data = din[1];

  // a direct bank write makes a cached copy of that address stale.
  assign upd_en[0]   = w0 & map_wr_vld[0] & (map_wr_bank[0] == wr_bank[0]);
  assign upd_row[0]  = wr_row[0];
  assign upd_vld[0]  = 1'b0;
  assign upd_bank[0] = wr_bank[0];

  assign upd_en[1]   = conflict | (w1 & map_wr_vld[1] & (map_wr_bank[1] == wr_bank[1]));
  assign upd_row[1]  = wr_row[1];
  assign upd_vld[1]  = conflict;
  assign upd_bank[1] = wr_bank[1];

  a_no_bank_collision: assert property (@(posedge clk) disable iff (rst)
    !(bank_a_en && bank_b_en && (bank_a_bank == bank_b_bank)))
    else $error("bank ports a and b write the same bank");

endmodule

`default_nettype wire

//--- test/tb_mem_2r2w.sv
`default_nettype none

module tb_mem_2r2w;

  localparam int WIDTH    = 16;
  localparam int NUM_VBNK = 4;
  localparam int NUM_VROW = 16;
  localparam int ADR_W    = $clog2(NUM_VBNK) + $clog2(NUM_VROW);

  logic                  clk    = 1'b0;
  logic                  rst    = 1'b1;
  logic [1:0]            write  = '0;
  logic [1:0]            read   = '0;
  logic [1:0][ADR_W-1:0] wr_adr = '0;
  logic [1:0][ADR_W-1:0] rd_adr = '0;
  logic [1:0][WIDTH-1:0] din    = '0;
  logic [1:0]            rd_vld;
  logic [1:0][WIDTH-1:0] rd_dout;
  logic                  ready;

  // reference model, one word per written address.
  logic [WIDTH-1:0]      model [int];
  logic [1:0]            exp_vld   = '0;
  logic [1:0]            exp_known = '0;
  logic [1:0][WIDTH-1:0] exp_data  = '0;
  logic [31:0]           lfsr      = 32'he90b;
  int                    errors    = 0;

  mem_2r2w_top #(.WIDTH(WIDTH), .NUM_VBNK(NUM_VBNK), .NUM_VROW(NUM_VROW)) mem_2r2w_top_i (
    .clk, .rst, .write, .wr_adr, .din, .read, .rd_adr, .rd_vld, .rd_dout, .ready
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // bank in the low bits, row above it.
  function automatic logic [ADR_W-1:0] adr_of(input int row, input int bank);
    return ADR_W'(row * NUM_VBNK + bank);
  endfunction

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_outputs();
    if (ready !== 1'b1) begin
      errors++;
      $display("FAIL t=%0t ready expected 1 got %b", $time, ready);
    end
    for (int p = 0; p < 2; p++) begin
      if (rd_vld[p] !== exp_vld[p]) begin
        errors++;
        $display("FAIL t=%0t rd_vld[%0d] expected %b got %b", $time, p, exp_vld[p], rd_vld[p]);
      end else if (exp_vld[p] && exp_known[p] && rd_dout[p] !== exp_data[p]) begin
        errors++;
        $display("FAIL t=%0t rd_dout[%0d] expected %h got %h", $time, p, exp_data[p], rd_dout[p]);
      end
    end
  endtask

  // one clock of strobes; the reads of the clock before are checked.
  task automatic cycle_op(input logic [1:0] wr, input logic [ADR_W-1:0] wa0, wa1,
                          input logic [WIDTH-1:0] d0, d1,
                          input logic [1:0] rd, input logic [ADR_W-1:0] ra0, ra1);
    logic [1:0][ADR_W-1:0] ra;
    logic [1:0]            nxt_known;
    logic [1:0][WIDTH-1:0] nxt_data;
    ra = {ra1, ra0};
    @(posedge clk);
    write  <= wr;
    wr_adr <= {wa1, wa0};
    din    <= {d1, d0};
    read   <= rd;
    rd_adr <= ra;
    for (int p = 0; p < 2; p++) begin
      nxt_known[p] = model.exists(int'(ra[p]));
      nxt_data[p]  = '0;
      if (nxt_known[p]) begin
        nxt_data[p] = model[int'(ra[p])];
      end
    end
    // reads see the old words; port 1 goes last so it wins a shared address.
    if (wr[0]) begin
      model[int'(wa0)] = d0;
    end
    if (wr[1]) begin
      model[int'(wa1)] = d1;
    end
    @(negedge clk);
    check_outputs();
    exp_vld   = rd;
    exp_known = nxt_known;
    exp_data  = nxt_data;
  endtask

  task automatic idle();
    cycle_op(2'b00, '0, '0, '0, '0, 2'b00, '0, '0);
  endtask

  task automatic test_reset_ready(output bit ok);
    int n;
    n = 0;
    @(negedge clk);
    if (ready !== 1'b0 || rd_vld !== 2'b00) begin
      errors++;
      $display("FAIL t=%0t ready, rd_vld expected 0, 00 got %b, %b", $time, ready, rd_vld);
    end
    // read strobes during the clearing sweep are dropped.
    while (ready !== 1'b1 && n < NUM_VROW + 8) begin
      @(posedge clk);
      n++;
      read <= (n < 4) ? 2'b11 : 2'b00;
      @(negedge clk);
      if (rd_vld !== 2'b00) begin
        errors++;
        $display("FAIL t=%0t rd_vld expected 00 got %b", $time, rd_vld);
      end
    end
    ok = (ready === 1'b1);
    if (!ok) begin
      errors++;
      $display("ready did not rise within %0d cycles of reset release", n);
    end else if (n != NUM_VROW) begin
      errors++;
      $display("FAIL t=%0t ready rise cycle expected %0d got %0d", $time, NUM_VROW, n);
    end
  endtask

  task automatic test_single_writes();
    logic [ADR_W-1:0] a0, a1;
    for (int i = 0; i < NUM_VBNK; i++) begin
      a0 = adr_of(i, i);
      a1 = adr_of(i + 4, (i + 1) % NUM_VBNK);
      cycle_op(2'b01, a0, '0, WIDTH'(16'h1000 + i), '0, 2'b00, '0, '0);
      cycle_op(2'b10, '0, a1, '0, WIDTH'(16'h2000 + i), 2'b11, a0, a0);
      cycle_op(2'b11, a1, a0, WIDTH'(16'h3000 + i), WIDTH'(16'h4000 + i), 2'b11, a1, a1);
      cycle_op(2'b00, '0, '0, '0, '0, 2'b11, a0, a1);
    end
    idle();
  endtask

  task automatic test_same_bank();
    logic [31:0] r;
    for (int i = 0; i < NUM_VBNK; i++) begin
      take_bits(32, r);
      cycle_op(2'b11, adr_of(i, i), adr_of(i + 8, i), r[15:0], r[31:16], 2'b00, '0, '0);
    end
    for (int i = 0; i < NUM_VBNK; i++) begin
      cycle_op(2'b00, '0, '0, '0, '0, 2'b11, adr_of(i, i), adr_of(i + 8, i));
      cycle_op(2'b00, '0, '0, '0, '0, 2'b11, adr_of(i + 8, i), adr_of(i, i));
    end
    idle();
  endtask

  task automatic test_eviction();
    logic [ADR_W-1:0] a5, b5;
    a5 = adr_of(5, 0);
    b5 = adr_of(5, 1);
    // bank 0 takes cache row 5, bank 1 claims it, then bank 0 again.
    cycle_op(2'b11, adr_of(2, 0), a5, 16'ha0a2, 16'ha0a5, 2'b00, '0, '0);
    cycle_op(2'b11, adr_of(3, 1), b5, 16'hb1b3, 16'hb1b5, 2'b11, a5, b5);
    cycle_op(2'b00, '0, '0, '0, '0, 2'b11, a5, b5);
    cycle_op(2'b11, adr_of(6, 0), a5, 16'ha0a6, 16'ha0b5, 2'b11, b5, a5);
    cycle_op(2'b00, '0, '0, '0, '0, 2'b11, b5, a5);
    cycle_op(2'b00, '0, '0, '0, '0, 2'b11, adr_of(2, 0), adr_of(3, 1));
    idle();
  endtask

  task automatic test_same_address();
    logic [ADR_W-1:0] a;
    a = adr_of(9, 3);
    cycle_op(2'b11, a, a, 16'h1111, 16'h2222, 2'b00, '0, '0);
    cycle_op(2'b01, a, '0, 16'h3333, '0, 2'b11, a, a);
    cycle_op(2'b10, '0, a, '0, 16'h4444, 2'b11, a, a);
    // a moves into the cache, then a dual write to a goes back to its bank.
    cycle_op(2'b11, adr_of(1, 3), a, 16'h5555, 16'h6666, 2'b11, a, a);
    cycle_op(2'b11, a, a, 16'h7777, 16'h8888, 2'b11, a, a);
    cycle_op(2'b00, '0, '0, '0, '0, 2'b11, a, a);
    idle();
  endtask

  task automatic test_random(input int cycles);
    logic [31:0] w, a, d, r;
    // fill all 16 addresses first so every read has a known word.
    for (int k = 0; k < 8; k++) begin
      cycle_op(2'b11, ADR_W'(2 * k), ADR_W'(2 * k + 1), WIDTH'(k), ~WIDTH'(k), 2'b00, '0, '0);
    end
    for (int n = 0; n < cycles; n++) begin
      take_bits(2, w);
      take_bits(8, a);
      take_bits(32, d);
      take_bits(10, r);
      cycle_op(w[1:0], ADR_W'(a[3:0]), ADR_W'(a[7:4]), d[15:0], d[31:16],
               r[1:0], ADR_W'(r[5:2]), ADR_W'(r[9:6]));
    end
    idle();
  endtask

  initial begin
    bit ok;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_reset_ready(ok);
    if (ok) begin
      test_single_writes();
      test_same_bank();
      test_eviction();
      test_same_address();
      test_random(400);
    end
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
